// File: verilog/core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// datapath and pc width.
`define CORE_XLEN 32

// architectural register count, x0 included.
`define CORE_NUM_REGS 32

// rob depth must stay a power of two so the tags wrap cleanly.
`define CORE_ROB_DEPTH 4
`define CORE_ROB_TAG_W 2

// rv32i major opcodes handled by the core.
`define CORE_OPC_OP 7'b0110011
`define CORE_OPC_OP_IMM 7'b0010011

`endif

// File: verilog/core_pkg.sv
`default_nettype none

`include "core_macros.svh"

package core_pkg;

    typedef logic [`CORE_XLEN-1:0] xlen_t;
    typedef logic [$clog2(`CORE_NUM_REGS)-1:0] reg_idx_t;
    typedef logic [`CORE_ROB_TAG_W-1:0] rob_tag_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_t;

    typedef struct packed {
        alu_op_t  op;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        xlen_t    imm;
        logic     use_imm;
        logic     uses_rs2;
        logic     writes_rd;
    } decoded_instr_t;

    // tag is the destination rob entry.
    typedef struct packed {
        logic     valid;
        alu_op_t  op;
        xlen_t    opa;
        xlen_t    opb;
        rob_tag_t tag;
    } issue_pkt_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        xlen_t    data;
    } complete_pkt_t;

    typedef struct packed {
        logic     valid;
        xlen_t    pc;
        reg_idx_t rd;
        logic     writes_rd;
        xlen_t    data;
    } retire_pkt_t;

endpackage

`default_nettype wire

// File: verilog/instr_decode.sv
`default_nettype none
`timescale 1ns/10ps

`include "core_macros.svh"

module instr_decode import core_pkg::*; (
    input  xlen_t          instr,
    output decoded_instr_t dec
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;
    logic       is_op;
    logic       is_op_imm;

    assign opcode    = instr[6:0];
    assign funct3    = instr[14:12];
    // funct7 bit 5 selects sub and sra.
    assign alt       = instr[30];
    assign is_op     = (opcode == `CORE_OPC_OP);
    assign is_op_imm = (opcode == `CORE_OPC_OP_IMM);

    always_comb begin
        dec.rd        = instr[11:7];
        dec.rs1       = instr[19:15];
        dec.rs2       = instr[24:20];
        dec.imm       = {{20{instr[31]}}, instr[31:20]};
        dec.use_imm   = !is_op;
        dec.uses_rs2  = is_op;
        dec.writes_rd = (is_op || is_op_imm) && (instr[11:7] != '0);

        case (funct3)
            3'b000:  dec.op = (is_op && alt) ? ALU_SUB : ALU_ADD;
            3'b001:  dec.op = ALU_SLL;
            3'b010:  dec.op = ALU_SLT;
            3'b011:  dec.op = ALU_SLTU;
            3'b100:  dec.op = ALU_XOR;
            3'b101:  dec.op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  dec.op = ALU_OR;
            default: dec.op = ALU_AND;
        endcase

        // unsupported opcodes become x0 + 0, no dependency and no write.
        if (!is_op && !is_op_imm) begin
            dec.op  = ALU_ADD;
            dec.rs1 = '0;
            dec.rs2 = '0;
            dec.imm = '0;
        end
    end

endmodule

`default_nettype wire

// File: verilog/rename_table.sv
`default_nettype none
`timescale 1ns/10ps

`include "core_macros.svh"

module rename_table import core_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  reg_idx_t    rs1_idx,
    input  reg_idx_t    rs2_idx,
    input  logic        alloc_valid,
    input  reg_idx_t    alloc_rd,
    input  rob_tag_t    alloc_tag,
    input  retire_pkt_t retire,
    input  rob_tag_t    retire_tag,
    output logic        rs1_busy,
    output logic        rs2_busy,
    output rob_tag_t    rs1_tag,
    output rob_tag_t    rs2_tag
);

    localparam int NREG = `CORE_NUM_REGS;

    logic [NREG-1:0] busy_q;
    rob_tag_t        tag_q [NREG];

    assign rs1_busy = busy_q[rs1_idx];
    assign rs2_busy = busy_q[rs2_idx];
    assign rs1_tag  = tag_q[rs1_idx];
    assign rs2_tag  = tag_q[rs2_idx];

    // dispatch wins over a retirement to the same register.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy_q <= '0;
        end else begin
            for (int i = 0; i < NREG; i++) begin
                if (alloc_valid && alloc_rd == reg_idx_t'(i)) begin
                    busy_q[i] <= 1'b1;
                end else if (retire.valid && retire.writes_rd &&
                             retire.rd == reg_idx_t'(i) && tag_q[i] == retire_tag) begin
                    busy_q[i] <= 1'b0;
                end
            end
        end
    end

    // tags only mean something while busy.
    always_ff @(posedge clk) begin
        if (alloc_valid) begin
            tag_q[alloc_rd] <= alloc_tag;
        end
    end

endmodule

`default_nettype wire

// File: verilog/reorder_buffer.sv
`default_nettype none
`timescale 1ns/10ps

`include "core_macros.svh"

module reorder_buffer import core_pkg::*; (
    input  logic          clk,
    input  logic          rstn,
    input  logic          alloc_valid,
    input  xlen_t         alloc_pc,
    input  reg_idx_t      alloc_rd,
    input  logic          alloc_writes_rd,
    input  complete_pkt_t complete,
    input  rob_tag_t      rd_tag_a,
    input  rob_tag_t      rd_tag_b,
    output logic          full,
    output rob_tag_t      alloc_tag,
    output logic          done_a,
    output logic          done_b,
    output xlen_t         value_a,
    output xlen_t         value_b,
    output retire_pkt_t   retire,
    output rob_tag_t      retire_tag
);

    localparam int DEPTH = `CORE_ROB_DEPTH;
    localparam int CNT_W = `CORE_ROB_TAG_W + 1;

    logic [DEPTH-1:0] valid_q;
    logic [DEPTH-1:0] done_q;
    logic [DEPTH-1:0] wr_q;
    xlen_t            pc_q [DEPTH];
    reg_idx_t         rd_q [DEPTH];
    xlen_t            value_q [DEPTH];
    rob_tag_t         head_q;
    rob_tag_t         tail_q;
    logic [CNT_W-1:0] count_q;
    logic             retire_fire;

    assign full      = (count_q == CNT_W'(DEPTH));
    assign alloc_tag = tail_q;

    // done is cleared on allocation, not on retire, so a retiring entry
    // still forwards during its retire cycle.
    assign done_a  = done_q[rd_tag_a];
    assign done_b  = done_q[rd_tag_b];
    assign value_a = value_q[rd_tag_a];
    assign value_b = value_q[rd_tag_b];

    assign retire_fire = valid_q[head_q] && done_q[head_q];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q    <= '0;
            done_q     <= '0;
            head_q     <= '0;
            tail_q     <= '0;
            count_q    <= '0;
            retire     <= '0;
            retire_tag <= '0;
        end else begin
            if (alloc_valid) begin
                valid_q[tail_q] <= 1'b1;
                done_q[tail_q]  <= 1'b0;
                tail_q          <= tail_q + 1'b1;
            end
            if (complete.valid) begin
                done_q[complete.tag] <= 1'b1;
            end
            if (retire_fire) begin
                valid_q[head_q] <= 1'b0;
                head_q          <= head_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(alloc_valid) - CNT_W'(retire_fire);

            // head goes out one cycle after it is seen done.
            retire.valid     <= retire_fire;
            retire.pc        <= pc_q[head_q];
            retire.rd        <= rd_q[head_q];
            retire.writes_rd <= wr_q[head_q];
            retire.data      <= value_q[head_q];
            retire_tag       <= head_q;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_valid) begin
            pc_q[tail_q] <= alloc_pc;
            rd_q[tail_q] <= alloc_rd;
            wr_q[tail_q] <= alloc_writes_rd;
        end
        if (complete.valid) begin
            value_q[complete.tag] <= complete.data;
        end
    end

    // dispatch must hold off while full.
    assert property (@(posedge clk) disable iff (!rstn) alloc_valid |-> !full);

    // each alu result lands once, on an entry still waiting for it.
    assert property (@(posedge clk) disable iff (!rstn)
        complete.valid |-> valid_q[complete.tag] && !done_q[complete.tag]);

endmodule

`default_nettype wire

// File: verilog/arch_reg_file.sv
`default_nettype none
`timescale 1ns/10ps

`include "core_macros.svh"

module arch_reg_file import core_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  reg_idx_t    rs1_idx,
    input  reg_idx_t    rs2_idx,
    input  retire_pkt_t retire,
    output xlen_t       rs1_value,
    output xlen_t       rs2_value
);

    localparam int NREG = `CORE_NUM_REGS;

    xlen_t regs_q [NREG];

    assign rs1_value = (rs1_idx == '0) ? '0 : regs_q[rs1_idx];
    assign rs2_value = (rs2_idx == '0) ? '0 : regs_q[rs2_idx];

    // committed state only, written in program order.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < NREG; i++) begin
                regs_q[i] <= '0;
            end
        end else if (retire.valid && retire.writes_rd && retire.rd != '0) begin
            regs_q[retire.rd] <= retire.data;
        end
    end

endmodule

`default_nettype wire

// File: verilog/dispatch_stage.sv
`default_nettype none
`timescale 1ns/10ps

module dispatch_stage import core_pkg::*; (
    input  logic           clk,
    input  logic           rstn,
    input  logic           instr_valid,
    input  decoded_instr_t dec,
    input  logic           rs1_busy,
    input  logic           rs2_busy,
    input  rob_tag_t       rs1_tag,
    input  rob_tag_t       rs2_tag,
    input  logic           done_a,
    input  logic           done_b,
    input  xlen_t          value_a,
    input  xlen_t          value_b,
    input  xlen_t          rf_a,
    input  xlen_t          rf_b,
    input  logic           rob_full,
    input  rob_tag_t       alloc_tag,
    output logic           stall,
    output logic           alloc_valid,
    output xlen_t          alloc_pc,
    output issue_pkt_t     issue
);

    xlen_t pc_q;
    logic  accept;
    logic  rs1_wait;
    logic  rs2_wait;
    xlen_t opa;
    xlen_t opb;

    // no same-cycle forwarding from the alu, so wait for done.
    assign rs1_wait = rs1_busy && !done_a;
    assign rs2_wait = dec.uses_rs2 && rs2_busy && !done_b;
    assign stall    = rob_full || rs1_wait || rs2_wait;

    assign accept      = instr_valid && !stall;
    assign alloc_valid = accept;
    assign alloc_pc    = pc_q;

    assign opa = rs1_busy ? value_a : rf_a;
    assign opb = dec.use_imm ? dec.imm : (rs2_busy ? value_b : rf_b);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pc_q <= '0;
        end else if (accept) begin
            pc_q <= pc_q + xlen_t'(4);
        end
    end

    // issue register, loaded on the accepting edge.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            issue <= '0;
        end else begin
            issue.valid <= accept;
            if (accept) begin
                issue.op  <= dec.op;
                issue.opa <= opa;
                issue.opb <= opb;
                issue.tag <= alloc_tag;
            end
        end
    end

    // a pending producer is a live rob entry, so it is never the free tail.
    assert property (@(posedge clk) disable iff (!rstn)
        rs1_wait |-> (rob_full || rs1_tag != alloc_tag));
    assert property (@(posedge clk) disable iff (!rstn)
        rs2_wait |-> (rob_full || rs2_tag != alloc_tag));

endmodule

`default_nettype wire

// File: verilog/alu_pipe.sv
`default_nettype none
`timescale 1ns/10ps

module alu_pipe import core_pkg::*; (
    input  logic          clk,
    input  logic          rstn,
    input  issue_pkt_t    issue,
    output complete_pkt_t complete
);

    xlen_t         result;
    logic [4:0]    shamt;
    complete_pkt_t stage1_q;

    assign shamt = issue.opb[4:0];

    always_comb begin
        case (issue.op)
            ALU_ADD:  result = issue.opa + issue.opb;
            ALU_SUB:  result = issue.opa - issue.opb;
            ALU_SLL:  result = issue.opa << shamt;
            ALU_SLT:  result = xlen_t'($signed(issue.opa) < $signed(issue.opb));
            ALU_SLTU: result = xlen_t'(issue.opa < issue.opb);
            ALU_XOR:  result = issue.opa ^ issue.opb;
            ALU_SRL:  result = issue.opa >> shamt;
            ALU_SRA:  result = xlen_t'($signed(issue.opa) >>> shamt);
            ALU_OR:   result = issue.opa | issue.opb;
            default:  result = issue.opa & issue.opb;
        endcase
    end

    // stage one.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            stage1_q <= '0;
        end else begin
            stage1_q.valid <= issue.valid;
            stage1_q.tag   <= issue.tag;
            stage1_q.data  <= result;
        end
    end

    // stage two, one packet per cycle with no bubbles.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            complete <= '0;
        end else begin
            complete <= stage1_q;
        end
    end

endmodule

`default_nettype wire

// File: verilog/ooo_core.sv
`default_nettype none
`timescale 1ns/10ps

module ooo_core import core_pkg::*; (
    input  logic     clk,
    input  logic     rstn,
    input  logic     instr_valid,
    input  xlen_t    instr,
    output logic     stall,
    output logic     retire_valid,
    output xlen_t    retire_pc,
    output reg_idx_t retire_rd,
    output logic     retire_writes_rd,
    output xlen_t    retire_data
);

    decoded_instr_t dec;
    logic           rs1_busy;
    logic           rs2_busy;
    rob_tag_t       rs1_tag;
    rob_tag_t       rs2_tag;
    logic           done_a;
    logic           done_b;
    xlen_t          value_a;
    xlen_t          value_b;
    xlen_t          rf_a;
    xlen_t          rf_b;
    logic           rob_full;
    rob_tag_t       alloc_tag;
    logic           alloc_valid;
    xlen_t          alloc_pc;
    issue_pkt_t     issue;
    complete_pkt_t  complete;
    retire_pkt_t    retire;
    rob_tag_t       retire_tag;

    assign retire_valid     = retire.valid;
    assign retire_pc        = retire.pc;
    assign retire_rd        = retire.rd;
    assign retire_writes_rd = retire.writes_rd;
    assign retire_data      = retire.data;

    instr_decode decode_i (
        .instr (instr),
        .dec   (dec)
    );

    // only register-writing instructions claim a mapping.
    rename_table rename_i (
        .clk         (clk),
        .rstn        (rstn),
        .rs1_idx     (dec.rs1),
        .rs2_idx     (dec.rs2),
        .alloc_valid (alloc_valid && dec.writes_rd),
        .alloc_rd    (dec.rd),
        .alloc_tag   (alloc_tag),
        .retire      (retire),
        .retire_tag  (retire_tag),
        .rs1_busy    (rs1_busy),
        .rs2_busy    (rs2_busy),
        .rs1_tag     (rs1_tag),
        .rs2_tag     (rs2_tag)
    );

    reorder_buffer rob_i (
        .clk             (clk),
        .rstn            (rstn),
        .alloc_valid     (alloc_valid),
        .alloc_pc        (alloc_pc),
        .alloc_rd        (dec.rd),
        .alloc_writes_rd (dec.writes_rd),
        .complete        (complete),
        .rd_tag_a        (rs1_tag),
        .rd_tag_b        (rs2_tag),
        .full            (rob_full),
        .alloc_tag       (alloc_tag),
        .done_a          (done_a),
        .done_b          (done_b),
        .value_a         (value_a),
        .value_b         (value_b),
        .retire          (retire),
        .retire_tag      (retire_tag)
    );

    arch_reg_file arf_i (
        .clk       (clk),
        .rstn      (rstn),
        .rs1_idx   (dec.rs1),
        .rs2_idx   (dec.rs2),
        .retire    (retire),
        .rs1_value (rf_a),
        .rs2_value (rf_b)
    );

    dispatch_stage dispatch_i (
        .clk         (clk),
        .rstn        (rstn),
        .instr_valid (instr_valid),
        .dec         (dec),
        .rs1_busy    (rs1_busy),
        .rs2_busy    (rs2_busy),
        .rs1_tag     (rs1_tag),
        .rs2_tag     (rs2_tag),
        .done_a      (done_a),
        .done_b      (done_b),
        .value_a     (value_a),
        .value_b     (value_b),
        .rf_a        (rf_a),
        .rf_b        (rf_b),
        .rob_full    (rob_full),
        .alloc_tag   (alloc_tag),
        .stall       (stall),
        .alloc_valid (alloc_valid),
        .alloc_pc    (alloc_pc),
        .issue       (issue)
    );

    alu_pipe alu_i (
        .clk      (clk),
        .rstn     (rstn),
        .issue    (issue),
        .complete (complete)
    );

endmodule

`default_nettype wire

// File: tests/tb_ooo_core.sv
`default_nettype none
`timescale 1ns/10ps

`include "core_macros.svh"

module tb_ooo_core import core_pkg::*; ();

    localparam int CLK_PERIOD   = 40;
    localparam int NUM_RANDOM   = 200;
    localparam int NUM_DIRECTED = 60;
    localparam int TOTAL_INSTRS = NUM_RANDOM + NUM_DIRECTED;
    localparam int WATCHDOG_NS  = (TOTAL_INSTRS * 20 + 5) * CLK_PERIOD;

    typedef struct packed {
        xlen_t    pc;
        reg_idx_t rd;
        logic     writes_rd;
        xlen_t    data;
    } expect_t;

    logic     clk;
    logic     rstn;
    logic     instr_valid;
    xlen_t    instr;
    logic     stall;
    logic     retire_valid;
    xlen_t    retire_pc;
    reg_idx_t retire_rd;
    logic     retire_writes_rd;
    xlen_t    retire_data;

    xlen_t   model_regs [`CORE_NUM_REGS];
    expect_t exp_q [$];
    expect_t accept_item;
    expect_t retire_item;
    xlen_t   exp_pc;
    integer  seed;
    string   test_name;

    ooo_core dut_i (
        .clk              (clk),
        .rstn             (rstn),
        .instr_valid      (instr_valid),
        .instr            (instr),
        .stall            (stall),
        .retire_valid     (retire_valid),
        .retire_pc        (retire_pc),
        .retire_rd        (retire_rd),
        .retire_writes_rd (retire_writes_rd),
        .retire_data      (retire_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string field, input xlen_t expected, input xlen_t actual);
        if (expected !== actual) begin
            $display("Error: test %s, %s expected 0x%08h actual 0x%08h",
                     test_name, field, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic xlen_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3,
                                    input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, `CORE_OPC_OP};
    endfunction

    function automatic xlen_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                    input logic [2:0] f3, input reg_idx_t rd);
        return {imm, rs1, f3, rd, `CORE_OPC_OP_IMM};
    endfunction

    function automatic logic is_supported(input xlen_t word);
        return (word[6:0] == `CORE_OPC_OP) || (word[6:0] == `CORE_OPC_OP_IMM);
    endfunction

    // rv32i semantics on the model register file.
    function automatic xlen_t ref_result(input xlen_t word);
        xlen_t      a;
        xlen_t      b;
        logic [4:0] sh;
        logic       is_op;
        is_op = (word[6:0] == `CORE_OPC_OP);
        a = model_regs[word[19:15]];
        if (is_op) begin
            b = model_regs[word[24:20]];
        end else begin
            b = {{20{word[31]}}, word[31:20]};
        end
        sh = b[4:0];
        case (word[14:12])
            3'd0:    ref_result = (is_op && word[30]) ? a - b : a + b;
            3'd1:    ref_result = a << sh;
            3'd2:    ref_result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    ref_result = (a < b) ? 32'd1 : 32'd0;
            3'd4:    ref_result = a ^ b;
            3'd5:    ref_result = word[30] ? xlen_t'($signed(a) >>> sh) : a >> sh;
            3'd6:    ref_result = a | b;
            default: ref_result = a & b;
        endcase
    endfunction

    // holds the word until the edge that accepts it.
    task automatic send_instr(input xlen_t word);
        instr_valid <= 1'b1;
        instr       <= word;
        @(posedge clk);
        while (stall) begin
            @(posedge clk);
        end
    endtask

    task automatic idle_cycles(input int n);
        instr_valid <= 1'b0;
        repeat (n) @(posedge clk);
    endtask

    task automatic drain_core();
        instr_valid <= 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
    endtask

    // model runs at acceptance, in program order.
    always @(posedge clk) begin
        if (rstn && instr_valid && !stall) begin
            accept_item.pc        = exp_pc;
            accept_item.rd        = instr[11:7];
            accept_item.writes_rd = is_supported(instr) && (instr[11:7] != 5'd0);
            accept_item.data      = is_supported(instr) ? ref_result(instr) : '0;
            if (accept_item.writes_rd) begin
                model_regs[accept_item.rd] = accept_item.data;
            end
            exp_q.push_back(accept_item);
            exp_pc = exp_pc + 32'd4;
        end
    end

    always @(posedge clk) begin
        if (rstn && retire_valid) begin
            if (exp_q.size() == 0) begin
                $display("Error: test %s, a retirement came with no instruction outstanding",
                         test_name);
                $display("*** TEST FAILED ***");
                $fatal(1, "unexpected retirement");
            end else begin
                retire_item = exp_q.pop_front();
                check_value("retire_pc", retire_item.pc, retire_pc);
                check_value("retire_writes_rd", xlen_t'(retire_item.writes_rd),
                            xlen_t'(retire_writes_rd));
                if (retire_item.writes_rd) begin
                    check_value("retire_rd", xlen_t'(retire_item.rd), xlen_t'(retire_rd));
                    check_value("retire_data", retire_item.data, retire_data);
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before all instructions retired");
        $display("*** TEST FAILED ***");
        $fatal(1, "timeout");
    end

    initial begin
        xlen_t word;
        int    kind;
        clk            = 1'b0;
        rstn           = 1'b0;
        instr_valid    = 1'b0;
        instr          = '0;
        exp_pc         = '0;
        seed           = 47;
        test_name      = "reset";
        for (int i = 0; i < `CORE_NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (5) @(posedge clk);
        rstn <= 1'b1;

        // idle core after reset.
        repeat (4) begin
            @(posedge clk);
            check_value("stall", '0, xlen_t'(stall));
            check_value("retire_valid", '0, xlen_t'(retire_valid));
        end

        test_name = "all_ops";
        send_instr(enc_i(12'h123, 5'd0, 3'd0, 5'd1));
        send_instr(enc_i(12'hffb, 5'd0, 3'd0, 5'd2));
        send_instr(enc_i(12'h007, 5'd0, 3'd0, 5'd3));
        drain_core();
        for (int f = 0; f < 8; f++) begin
            send_instr(enc_r(7'h00, 5'd2, 5'd1, 3'(f), 5'(4 + f)));
        end
        send_instr(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd12));
        send_instr(enc_r(7'h20, 5'd3, 5'd2, 3'd5, 5'd13));
        for (int f = 0; f < 8; f++) begin
            send_instr(enc_i((f == 1 || f == 5) ? 12'h003 : 12'h8f0, 5'd2, 3'(f), 5'(14 + f)));
        end
        send_instr(enc_i(12'h404, 5'd2, 3'd5, 5'd22));
        drain_core();

        test_name = "dependent_chains";
        send_instr(enc_i(12'h001, 5'd1, 3'd0, 5'd14));
        send_instr(enc_r(7'h00, 5'd14, 5'd14, 3'd0, 5'd15));
        send_instr(enc_r(7'h20, 5'd14, 5'd15, 3'd0, 5'd16));
        send_instr(enc_i(12'h002, 5'd16, 3'd1, 5'd17));
        send_instr(enc_r(7'h00, 5'd15, 5'd17, 3'd4, 5'd18));
        send_instr(enc_i(12'hfff, 5'd18, 3'd0, 5'd18));
        send_instr(enc_i(12'h001, 5'd0, 3'd0, 5'd20));
        repeat (6) send_instr(enc_r(7'h00, 5'd20, 5'd20, 3'd0, 5'd20));
        drain_core();

        test_name = "rob_full_burst";
        for (int i = 0; i < 12; i++) begin
            send_instr(enc_i(12'(i * 3 + 1), 5'd0, 3'd0, 5'(21 + i % 8)));
        end
        drain_core();

        test_name = "x0_and_unsupported";
        send_instr(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd0));
        send_instr(enc_i(12'h005, 5'd0, 3'd0, 5'd0));
        send_instr(32'h0040_a183);
        send_instr(32'h0000_0073);
        send_instr(enc_r(7'h00, 5'd0, 5'd0, 3'd6, 5'd29));
        send_instr(enc_r(7'h00, 5'd1, 5'd0, 3'd0, 5'd30));
        drain_core();

        test_name = "random";
        for (int n = 0; n < NUM_RANDOM; n++) begin
            word = $random(seed);
            kind = $unsigned($random(seed)) % 4;
            if (kind == 3) begin
                if (is_supported(word)) begin
                    word[6:0] = 7'b1110011;
                end
            end else begin
                word[6:0]   = (kind == 0) ? `CORE_OPC_OP : `CORE_OPC_OP_IMM;
                word[11:7]  = 5'($unsigned($random(seed)) % 8);
                word[19:15] = 5'($unsigned($random(seed)) % 8);
                if (kind == 0) begin
                    word[24:20] = 5'($unsigned($random(seed)) % 8);
                    word[31:25] = word[31] ? 7'h20 : 7'h00;
                end
            end
            send_instr(word);
            if (($unsigned($random(seed)) % 4) == 0) begin
                idle_cycles(1 + $unsigned($random(seed)) % 3);
            end
        end
        drain_core();

        test_name = "final";
        repeat (10) @(posedge clk);
        // a drained core has a free rob and no pending sources.
        check_value("stall", '0, xlen_t'(stall));
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: ooo_core.f
+incdir+verilog
verilog/core_pkg.sv
verilog/instr_decode.sv
verilog/rename_table.sv
verilog/reorder_buffer.sv
verilog/arch_reg_file.sv
verilog/dispatch_stage.sv
verilog/alu_pipe.sv
verilog/ooo_core.sv
tests/tb_ooo_core.sv
